// ==== common/sat_consts.svh ====
// size defines for one SAT bin, included by the package and by any RTL that loops over them
`ifndef SAT_CONSTS_SVH
`define SAT_CONSTS_SVH

// variables held by one bin
`define SAT_NUM_VARS 8

// clause slots in the evaluator
`define SAT_NUM_CLAUSES 8

// decision level width
`define SAT_LVL_W 8

// index widths for variables and clause slots
`define SAT_VAR_IDX_W 3
`define SAT_CLS_IDX_W 3

`endif

// ==== common/sat_pkg.sv ====
// shared types of the SAT bin: values, literals, commands, responses and controller states
`default_nettype none

`include "sat_consts.svh"

package sat_pkg;

    typedef logic [`SAT_LVL_W-1:0] lvl_t;
    typedef logic [`SAT_VAR_IDX_W-1:0] var_idx_t;
    typedef logic [`SAT_CLS_IDX_W-1:0] cls_idx_t;

    // 11 marks a variable during conflict analysis
    typedef enum logic [1:0] {
        POL_NONE  = 2'b00,
        POL_FALSE = 2'b01,
        POL_TRUE  = 2'b10,
        POL_MARK  = 2'b11
    } pol_e;

    typedef struct packed {
        pol_e pol;
        logic implied;
    } var_val_t;

    // same encoding as the polarity, so a literal is true when the two match
    typedef enum logic [1:0] {
        LIT_NONE = 2'b00,
        LIT_NEG  = 2'b01,
        LIT_POS  = 2'b10
    } lit_t;

    typedef lit_t [`SAT_NUM_VARS-1:0] lit_vec_t;
    typedef var_val_t [`SAT_NUM_VARS-1:0] val_vec_t;
    typedef lvl_t [`SAT_NUM_VARS-1:0] lvl_vec_t;

    typedef struct packed {
        var_val_t val;
        lvl_t lvl;
    } var_rec_t;

    typedef enum logic [2:0] {
        OP_LOAD,
        OP_READ,
        OP_CLAUSE_WR,
        OP_DECIDE,
        OP_PROPAGATE,
        OP_ANALYZE,
        OP_BACKTRACK
    } sat_op_e;

    typedef struct packed {
        sat_op_e op;
        var_idx_t var_idx;
        cls_idx_t cls_idx;
        logic pol;
        var_rec_t rec;
        lit_vec_t lits;
    } sat_cmd_t;

    typedef struct packed {
        logic conflict;
        cls_idx_t conf_idx;
        lvl_t cur_lvl;
        lvl_t bkt_lvl;
        lit_vec_t learnt;
        var_rec_t rec;
    } sat_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        PROP,
        MARK,
        COLLECT,
        REDUCE,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== var_bin/var_state.sv ====
// value, level, saved value and learnt literal of a single variable in the bin
`default_nettype none

module var_state import sat_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    // load and readback
    input  wire logic     wr_i,
    input  var_rec_t      rec_i,
    output var_rec_t      rec_o,
    // decide
    input  wire logic     decide_i,
    input  wire logic     pol_i,
    input  lvl_t          cur_lvl_i,
    // imply
    input  wire logic     imply_i,
    input  var_val_t      imp_val_i,
    input  lvl_t          imp_lvl_i,
    // conflict analysis
    input  wire logic     analyze_i,
    input  wire logic     mark_i,
    // backtrack
    input  wire logic     bkt_i,
    input  lvl_t          bkt_lvl_i,
    output var_val_t      val_o,
    output lvl_t          lvl_o,
    output lit_t          learnt_o,
    output lvl_t          max_lvl_o
);

    var_val_t val_q;
    var_val_t saved_q;
    lvl_t lvl_q;
    lit_t learnt_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            val_q <= '0;
            lvl_q <= '0;
        end else if (wr_i) begin
            val_q <= rec_i.val;
            lvl_q <= rec_i.lvl;
        end else if (decide_i) begin
            val_q.pol <= pol_i ? POL_TRUE : POL_FALSE;
            val_q.implied <= 1'b0;
            lvl_q <= cur_lvl_i;
        end else if (imply_i && val_q.pol == POL_NONE && imp_val_i.pol != POL_NONE) begin
            val_q <= imp_val_i;
            lvl_q <= imp_lvl_i;
        end else if (analyze_i && mark_i) begin
            val_q.pol <= POL_MARK;
        end else if (bkt_i && lvl_q > bkt_lvl_i) begin
            val_q <= '0;
            lvl_q <= '0;
        end else if (bkt_i && learnt_q != LIT_NONE) begin
            // flip at the backtrack level, marked vars below it get their value back
            val_q.pol <= (lvl_q == bkt_lvl_i) ? pol_e'(~saved_q.pol) : saved_q.pol;
            val_q.implied <= saved_q.implied;
        end
    end

    // value before marking, kept until the backtrack consumes it
    always_ff @(posedge clk) begin
        if (!analyze_i && val_q.pol != POL_MARK) begin
            saved_q <= val_q;
        end
    end

    // reason is outside the bin, so every marked var goes into the learnt clause
    always_ff @(posedge clk) begin
        if (!rst) begin
            learnt_q <= LIT_NONE;
        end else if (val_q.pol == POL_MARK) begin
            learnt_q <= lit_t'(~saved_q.pol);
        end else if (!analyze_i) begin
            learnt_q <= LIT_NONE;
        end
    end

    assign rec_o = '{val: val_q, lvl: lvl_q};
    assign val_o = val_q;
    assign lvl_o = lvl_q;
    assign learnt_o = learnt_q;
    assign max_lvl_o = (learnt_q != LIT_NONE) ? lvl_q : '0;

endmodule

`default_nettype wire

// ==== var_bin/var_bin.sv ====
// array of variable states with a shared command fan-out and flat value and level views
`default_nettype none

`include "sat_consts.svh"

module var_bin import sat_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic wr_i,
    input  var_idx_t  sel_i,
    input  var_rec_t  rec_i,
    output var_rec_t  rec_o,
    input  wire logic decide_i,
    input  wire logic pol_i,
    input  lvl_t      cur_lvl_i,
    input  wire logic imply_i,
    input  val_vec_t  imp_vals_i,
    input  lvl_t      imp_lvl_i,
    input  wire logic analyze_i,
    input  wire logic [`SAT_NUM_VARS-1:0] mark_mask_i,
    input  wire logic bkt_i,
    input  lvl_t      bkt_lvl_i,
    output val_vec_t  vals_o,
    output lvl_vec_t  lvls_o,
    output lit_vec_t  learnt_o,
    output lvl_vec_t  max_lvls_o
);

    var_rec_t recs [`SAT_NUM_VARS];

    for (genvar i = 0; i < `SAT_NUM_VARS; i++) begin : g_var
        // load and decide only reach the selected variable
        var_state u_var_state (
            .clk        (clk),
            .rst        (rst),
            .wr_i       (wr_i && sel_i == var_idx_t'(i)),
            .rec_i      (rec_i),
            .rec_o      (recs[i]),
            .decide_i   (decide_i && sel_i == var_idx_t'(i)),
            .pol_i      (pol_i),
            .cur_lvl_i  (cur_lvl_i),
            .imply_i    (imply_i),
            .imp_val_i  (imp_vals_i[i]),
            .imp_lvl_i  (imp_lvl_i),
            .analyze_i  (analyze_i),
            .mark_i     (mark_mask_i[i]),
            .bkt_i      (bkt_i),
            .bkt_lvl_i  (bkt_lvl_i),
            .val_o      (vals_o[i]),
            .lvl_o      (lvls_o[i]),
            .learnt_o   (learnt_o[i]),
            .max_lvl_o  (max_lvls_o[i])
        );
    end

    // readback mux
    assign rec_o = recs[sel_i];

endmodule

`default_nettype wire

// ==== logic/clause_eval.sv ====
// clause storage with combinational unit and conflict detection over current values
`default_nettype none

`include "sat_consts.svh"

module clause_eval import sat_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cls_wr_i,
    input  cls_idx_t  cls_idx_i,
    input  lit_vec_t  cls_lits_i,
    input  val_vec_t  vals_i,
    output logic      unit_o,
    output val_vec_t  imp_vals_o,
    output logic      conflict_o,
    output cls_idx_t  conf_idx_o,
    output lit_vec_t  conf_lits_o
);

    lit_vec_t cls_q [`SAT_NUM_CLAUSES];
    logic [`SAT_NUM_CLAUSES-1:0] valid_q;

    always_ff @(posedge clk) begin
        if (cls_wr_i) begin
            cls_q[cls_idx_i] <= cls_lits_i;
        end
    end

    // a clause without literals counts as an empty slot
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
        end else if (cls_wr_i) begin
            valid_q[cls_idx_i] <= |cls_lits_i;
        end
    end

    always_comb begin
        logic sat;
        logic one_un;
        logic many_un;
        var_idx_t un_idx;
        unit_o = 1'b0;
        imp_vals_o = '0;
        conflict_o = 1'b0;
        conf_idx_o = '0;
        for (int c = 0; c < `SAT_NUM_CLAUSES; c++) begin
            sat = 1'b0;
            one_un = 1'b0;
            many_un = 1'b0;
            un_idx = '0;
            for (int v = 0; v < `SAT_NUM_VARS; v++) begin
                if (cls_q[c][v] != LIT_NONE) begin
                    if (vals_i[v].pol == POL_NONE) begin
                        many_un = many_un | one_un;
                        one_un = 1'b1;
                        un_idx = var_idx_t'(v);
                    end else if (vals_i[v].pol == pol_e'(cls_q[c][v])) begin
                        sat = 1'b1;
                    end
                end
            end
            if (valid_q[c] && !sat) begin
                if (!one_un && !conflict_o) begin
                    // lowest falsified clause wins
                    conflict_o = 1'b1;
                    conf_idx_o = cls_idx_t'(c);
                end else if (one_un && !many_un && imp_vals_o[un_idx].pol == POL_NONE) begin
                    // opposing implications surface as a conflict next cycle
                    unit_o = 1'b1;
                    imp_vals_o[un_idx].pol = pol_e'(cls_q[c][un_idx]);
                    imp_vals_o[un_idx].implied = 1'b1;
                end
            end
        end
    end

    assign conf_lits_o = conflict_o ? cls_q[conf_idx_o] : '0;

endmodule

`default_nettype wire

// ==== logic/sat_bin_ctrl.sv ====
// command FSM of the SAT bin, sequences propagate and analyze and owns the decision level
`default_nettype none

`include "sat_consts.svh"

module sat_bin_ctrl import sat_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cmd_valid_i,
    input  sat_cmd_t  cmd_i,
    output logic      busy_o,
    output logic      done_o,
    output sat_rsp_t  rsp_o,
    // variable bin
    output logic      wr_o,
    output var_idx_t  sel_o,
    output var_rec_t  rec_o,
    input  var_rec_t  rec_i,
    output logic      decide_o,
    output logic      pol_o,
    output lvl_t      cur_lvl_o,
    output logic      imply_o,
    output val_vec_t  imp_vals_o,
    output lvl_t      imp_lvl_o,
    output logic      analyze_o,
    output logic [`SAT_NUM_VARS-1:0] mark_mask_o,
    output logic      bkt_o,
    output lvl_t      bkt_lvl_o,
    // clause evaluator
    output logic      cls_wr_o,
    input  wire logic unit_i,
    input  val_vec_t  imp_vals_i,
    input  wire logic conflict_i,
    input  cls_idx_t  conf_idx_i,
    input  lit_vec_t  conf_lits_i,
    input  lit_vec_t  learnt_i,
    input  lvl_vec_t  max_lvls_i
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    sat_rsp_t rsp_q;
    logic accept;
    lvl_t bkt_calc;

    // DONE still takes commands
    assign busy_o = !(state_q == IDLE || state_q == DONE);
    assign done_o = state_q == DONE;
    assign rsp_o = rsp_q;
    assign accept = cmd_valid_i && !busy_o;

    assign wr_o = accept && cmd_i.op == OP_LOAD;
    assign sel_o = cmd_i.var_idx;
    assign rec_o = cmd_i.rec;
    assign decide_o = accept && cmd_i.op == OP_DECIDE;
    assign pol_o = cmd_i.pol;
    // decided var lands on the new level
    assign cur_lvl_o = decide_o ? rsp_q.cur_lvl + 1'b1 : rsp_q.cur_lvl;
    assign cls_wr_o = accept && cmd_i.op == OP_CLAUSE_WR;

    assign imply_o = state_q == PROP && unit_i && !conflict_i;
    assign imp_vals_o = imply_o ? imp_vals_i : '0;
    assign imp_lvl_o = rsp_q.cur_lvl;
    assign analyze_o = state_q inside {MARK, COLLECT, REDUCE};
    assign bkt_o = accept && cmd_i.op == OP_BACKTRACK;
    assign bkt_lvl_o = rsp_q.bkt_lvl;

    // mark the conflict clause while values are still intact
    always_comb begin
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            mark_mask_o[v] = state_q == MARK && conf_lits_i[v] != LIT_NONE;
        end
    end

    // highest learnt level below the current one
    always_comb begin
        bkt_calc = '0;
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            if (max_lvls_i[v] < rsp_q.cur_lvl && max_lvls_i[v] > bkt_calc) begin
                bkt_calc = max_lvls_i[v];
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE, DONE: begin
                state_d = IDLE;
                if (accept) begin
                    case (cmd_i.op)
                        OP_PROPAGATE: state_d = PROP;
                        OP_ANALYZE:   state_d = MARK;
                        default:      state_d = DONE;
                    endcase
                end
            end
            // loop until fixpoint or conflict
            PROP: begin
                if (conflict_i || !unit_i) begin
                    state_d = DONE;
                end
            end
            MARK:    state_d = COLLECT;
            COLLECT: state_d = REDUCE;
            REDUCE:  state_d = DONE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= IDLE;
            rsp_q <= '0;
        end else begin
            state_q <= state_d;
            if (accept && cmd_i.op == OP_READ) begin
                rsp_q.rec <= rec_i;
            end
            if (decide_o) begin
                rsp_q.cur_lvl <= cur_lvl_o;
            end
            if (bkt_o) begin
                rsp_q.cur_lvl <= rsp_q.bkt_lvl;
            end
            if (state_q == PROP && state_d == DONE) begin
                rsp_q.conflict <= conflict_i;
                rsp_q.conf_idx <= conflict_i ? conf_idx_i : '0;
            end
            if (state_q == REDUCE) begin
                rsp_q.bkt_lvl <= bkt_calc;
                rsp_q.learnt <= learnt_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sat_bin_top.sv ====
// top of one SAT bin, joins the command controller, clause evaluator and variable bin
`default_nettype none

`include "sat_consts.svh"

module sat_bin_top import sat_pkg::*; (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic cmd_valid_i,
    input  sat_cmd_t  cmd_i,
    output logic      busy_o,
    output logic      done_o,
    output sat_rsp_t  rsp_o
);

    logic wr;
    var_idx_t sel;
    var_rec_t wr_rec;
    var_rec_t rd_rec;
    logic decide;
    logic pol;
    lvl_t cur_lvl;
    logic imply;
    val_vec_t ctrl_imp_vals;
    val_vec_t cls_imp_vals;
    lvl_t imp_lvl;
    logic analyze;
    logic [`SAT_NUM_VARS-1:0] mark_mask;
    logic bkt;
    lvl_t bkt_lvl;
    logic cls_wr;
    logic unit;
    logic conflict;
    cls_idx_t conf_idx;
    lit_vec_t conf_lits;
    val_vec_t vals;
    lit_vec_t learnt;
    lvl_vec_t max_lvls;

    sat_bin_ctrl u_ctrl (
        .clk, .rst, .cmd_valid_i, .cmd_i, .busy_o, .done_o, .rsp_o,
        .wr_o (wr), .sel_o (sel), .rec_o (wr_rec), .rec_i (rd_rec),
        .decide_o (decide), .pol_o (pol), .cur_lvl_o (cur_lvl),
        .imply_o (imply), .imp_vals_o (ctrl_imp_vals), .imp_lvl_o (imp_lvl),
        .analyze_o (analyze), .mark_mask_o (mark_mask),
        .bkt_o (bkt), .bkt_lvl_o (bkt_lvl), .cls_wr_o (cls_wr),
        .unit_i (unit), .imp_vals_i (cls_imp_vals), .conflict_i (conflict),
        .conf_idx_i (conf_idx), .conf_lits_i (conf_lits),
        .learnt_i (learnt), .max_lvls_i (max_lvls)
    );

    clause_eval u_clause_eval (
        .clk, .rst,
        .cls_wr_i (cls_wr), .cls_idx_i (cmd_i.cls_idx), .cls_lits_i (cmd_i.lits),
        .vals_i (vals), .unit_o (unit), .imp_vals_o (cls_imp_vals),
        .conflict_o (conflict), .conf_idx_o (conf_idx), .conf_lits_o (conf_lits)
    );

    var_bin u_var_bin (
        .clk, .rst,
        .wr_i (wr), .sel_i (sel), .rec_i (wr_rec), .rec_o (rd_rec),
        .decide_i (decide), .pol_i (pol), .cur_lvl_i (cur_lvl),
        .imply_i (imply), .imp_vals_i (ctrl_imp_vals), .imp_lvl_i (imp_lvl),
        .analyze_i (analyze), .mark_mask_i (mark_mask),
        .bkt_i (bkt), .bkt_lvl_i (bkt_lvl),
        .vals_o (vals), .lvls_o (), .learnt_o (learnt), .max_lvls_o (max_lvls)
    );

endmodule

`default_nettype wire

// ==== verif/tb_sat_bin.sv ====
// testbench for one SAT bin, runs host command sequences and checks responses against a model
`default_nettype none

`include "sat_consts.svh"

module tb_sat_bin import sat_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    // roughly 20 times the longest command sequence
    localparam int MAX_CYCLES = 4000;

    logic clk;
    logic rst;
    logic cmd_valid_i;
    sat_cmd_t cmd_i;
    logic busy_o;
    logic done_o;
    sat_rsp_t rsp_o;

    int seed = 88;
    int err_cnt = 0;
    int test_cnt = 0;
    int test_fail = 0;
    int test_err_base = 0;
    int cycle_cnt = 0;

    // reference model state
    var_val_t m_val [`SAT_NUM_VARS];
    lvl_t m_lvl [`SAT_NUM_VARS];
    lit_vec_t m_cls [`SAT_NUM_CLAUSES];
    lvl_t m_cur;

    // expected response, compared while done_o is high
    logic chk_rec;
    logic chk_prop;
    logic chk_ana;
    var_rec_t exp_rec;
    logic exp_conflict;
    cls_idx_t exp_conf_idx;
    lit_vec_t exp_learnt;
    lvl_t exp_bkt;

    logic rst_q;
    logic single_q;
    logic [3:0] ana_q;

    sat_bin_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .busy_o      (busy_o),
        .done_o      (done_o),
        .rsp_o       (rsp_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // accepted commands, delayed to the cycle where done_o is due
    always @(posedge clk) begin
        rst_q <= rst;
        if (!rst) begin
            single_q <= 1'b0;
            ana_q <= '0;
        end else begin
            single_q <= cmd_valid_i && !busy_o
                && !(cmd_i.op inside {OP_PROPAGATE, OP_ANALYZE});
            ana_q <= {ana_q[2:0], cmd_valid_i && !busy_o && cmd_i.op == OP_ANALYZE};
        end
    end

    assert property (@(posedge clk) disable iff (!rst) (rst && !rst_q) |-> rsp_o == '0)
        else begin
            $display("Fail rsp_o: got %h expected %h", $sampled(rsp_o), 0);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (rst && !rst_q) |-> {busy_o, done_o} == 2'b00)
        else begin
            $display("Fail {busy_o,done_o}: got %h expected %h",
                $sampled({busy_o, done_o}), 2'b00);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst) single_q |-> done_o)
        else begin
            $display("Fail done_o: got %h expected %h", $sampled(done_o), 1'b1);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst) ana_q[3] |-> done_o)
        else begin
            $display("Fail done_o: got %h expected %h", $sampled(done_o), 1'b1);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst) (|ana_q[2:0]) |-> !done_o)
        else begin
            $display("Fail done_o: got %h expected %h", $sampled(done_o), 1'b0);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst) (|ana_q[2:0]) |-> busy_o)
        else begin
            $display("Fail busy_o: got %h expected %h", $sampled(busy_o), 1'b1);
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst) done_o |-> rsp_o.cur_lvl == m_cur)
        else begin
            $display("Fail rsp_o.cur_lvl: got %h expected %h",
                $sampled(rsp_o.cur_lvl), $sampled(m_cur));
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (done_o && chk_rec) |-> rsp_o.rec == exp_rec)
        else begin
            $display("Fail rsp_o.rec: got %h expected %h",
                $sampled(rsp_o.rec), $sampled(exp_rec));
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (done_o && chk_prop) |-> rsp_o.conflict == exp_conflict)
        else begin
            $display("Fail rsp_o.conflict: got %h expected %h",
                $sampled(rsp_o.conflict), $sampled(exp_conflict));
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (done_o && chk_prop) |-> rsp_o.conf_idx == exp_conf_idx)
        else begin
            $display("Fail rsp_o.conf_idx: got %h expected %h",
                $sampled(rsp_o.conf_idx), $sampled(exp_conf_idx));
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (done_o && chk_ana) |-> rsp_o.learnt == exp_learnt)
        else begin
            $display("Fail rsp_o.learnt: got %h expected %h",
                $sampled(rsp_o.learnt), $sampled(exp_learnt));
            err_cnt = err_cnt + 1;
        end
    assert property (@(posedge clk) disable iff (!rst)
        (done_o && chk_ana) |-> rsp_o.bkt_lvl == exp_bkt)
        else begin
            $display("Fail rsp_o.bkt_lvl: got %h expected %h",
                $sampled(rsp_o.bkt_lvl), $sampled(exp_bkt));
            err_cnt = err_cnt + 1;
        end

    function automatic sat_cmd_t make_cmd(input sat_op_e op);
        sat_cmd_t c;
        c = '0;
        c.op = op;
        return c;
    endfunction

    function automatic lit_t lit_of(input logic pos);
        return pos ? LIT_POS : LIT_NEG;
    endfunction

    function automatic logic lit_is_true(input lit_t lit, input pol_e pol);
        return (lit == LIT_POS && pol == POL_TRUE) || (lit == LIT_NEG && pol == POL_FALSE);
    endfunction

    // one-cycle strobe from a falling edge, then wait for done_o
    task automatic issue_cmd(input sat_cmd_t c);
        cmd_i = c;
        cmd_valid_i = 1'b1;
        @(negedge clk);
        cmd_valid_i = 1'b0;
        while (!done_o) begin
            @(negedge clk);
        end
        // the done cycle is checked at the next rising edge
        @(negedge clk);
        chk_rec = 1'b0;
        chk_prop = 1'b0;
        chk_ana = 1'b0;
    endtask

    task automatic load_var(input int v, input var_rec_t rec);
        sat_cmd_t c;
        c = make_cmd(OP_LOAD);
        c.var_idx = var_idx_t'(v);
        c.rec = rec;
        m_val[v] = rec.val;
        m_lvl[v] = rec.lvl;
        issue_cmd(c);
    endtask

    task automatic read_var(input int v);
        sat_cmd_t c;
        c = make_cmd(OP_READ);
        c.var_idx = var_idx_t'(v);
        exp_rec.val = m_val[v];
        exp_rec.lvl = m_lvl[v];
        chk_rec = 1'b1;
        issue_cmd(c);
    endtask

    task automatic read_all_vars();
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            read_var(v);
        end
    endtask

    task automatic write_clause(input int idx, input lit_vec_t lits);
        sat_cmd_t c;
        c = make_cmd(OP_CLAUSE_WR);
        c.cls_idx = cls_idx_t'(idx);
        c.lits = lits;
        m_cls[idx] = lits;
        issue_cmd(c);
    endtask

    task automatic decide_var(input int v, input logic pos);
        sat_cmd_t c;
        c = make_cmd(OP_DECIDE);
        c.var_idx = var_idx_t'(v);
        c.pol = pos;
        m_cur = m_cur + lvl_t'(1);
        m_val[v].pol = pos ? POL_TRUE : POL_FALSE;
        m_val[v].implied = 1'b0;
        m_lvl[v] = m_cur;
        issue_cmd(c);
    endtask

    task automatic propagate();
        sat_cmd_t c;
        lit_t imp [`SAT_NUM_VARS];
        logic fixpoint;
        logic is_true;
        int n_un;
        int un_v;
        exp_conflict = 1'b0;
        exp_conf_idx = '0;
        fixpoint = 1'b0;
        // one pass per propagation cycle
        while (!fixpoint && !exp_conflict) begin
            fixpoint = 1'b1;
            for (int v = 0; v < `SAT_NUM_VARS; v++) begin
                imp[v] = LIT_NONE;
            end
            for (int k = 0; k < `SAT_NUM_CLAUSES; k++) begin
                is_true = 1'b0;
                n_un = 0;
                un_v = 0;
                for (int v = 0; v < `SAT_NUM_VARS; v++) begin
                    if (m_cls[k][v] != LIT_NONE && m_val[v].pol == POL_NONE) begin
                        n_un++;
                        un_v = v;
                    end else if (lit_is_true(m_cls[k][v], m_val[v].pol)) begin
                        is_true = 1'b1;
                    end
                end
                if (m_cls[k] != '0 && !is_true) begin
                    if (n_un == 0 && !exp_conflict) begin
                        exp_conflict = 1'b1;
                        exp_conf_idx = cls_idx_t'(k);
                    end else if (n_un == 1 && imp[un_v] == LIT_NONE) begin
                        // lowest clause decides a contested variable
                        imp[un_v] = m_cls[k][un_v];
                    end
                end
            end
            for (int v = 0; v < `SAT_NUM_VARS; v++) begin
                if (!exp_conflict && imp[v] != LIT_NONE) begin
                    m_val[v].pol = (imp[v] == LIT_POS) ? POL_TRUE : POL_FALSE;
                    m_val[v].implied = 1'b1;
                    m_lvl[v] = m_cur;
                    fixpoint = 1'b0;
                end
            end
        end
        c = make_cmd(OP_PROPAGATE);
        chk_prop = 1'b1;
        issue_cmd(c);
    endtask

    // learnt clause negates the falsified assignments of the conflict clause
    task automatic analyze_conflict();
        sat_cmd_t c;
        exp_learnt = '0;
        exp_bkt = '0;
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            if (m_cls[exp_conf_idx][v] != LIT_NONE) begin
                exp_learnt[v] = (m_val[v].pol == POL_TRUE) ? LIT_NEG : LIT_POS;
                if (m_lvl[v] < m_cur && m_lvl[v] > exp_bkt) begin
                    exp_bkt = m_lvl[v];
                end
            end
        end
        c = make_cmd(OP_ANALYZE);
        chk_ana = 1'b1;
        issue_cmd(c);
    endtask

    task automatic backtrack();
        sat_cmd_t c;
        for (int v = 0; v < `SAT_NUM_VARS; v++) begin
            if (m_lvl[v] > exp_bkt) begin
                m_val[v] = '0;
                m_lvl[v] = '0;
            end else if (exp_learnt[v] != LIT_NONE && m_lvl[v] == exp_bkt) begin
                m_val[v].pol = (m_val[v].pol == POL_TRUE) ? POL_FALSE : POL_TRUE;
            end
        end
        m_cur = exp_bkt;
        c = make_cmd(OP_BACKTRACK);
        issue_cmd(c);
    endtask

    task automatic finish_test(input string name);
        test_cnt++;
        if (err_cnt == test_err_base) begin
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: failed with %0d errors", test_cnt, name,
                err_cnt - test_err_base);
        end
        test_err_base = err_cnt;
    endtask

    initial begin
        int r;
        int v;
        var_rec_t rec;
        lit_vec_t lits;
        logic [4:0] ch;
        cmd_valid_i = 1'b0;
        cmd_i = '0;
        rst = 1'b0;
        m_cur = '0;
        chk_rec = 1'b0;
        chk_prop = 1'b0;
        chk_ana = 1'b0;
        exp_rec = '0;
        exp_conflict = 1'b0;
        exp_conf_idx = '0;
        exp_learnt = '0;
        exp_bkt = '0;
        for (int i = 0; i < `SAT_NUM_VARS; i++) begin
            m_val[i] = '0;
            m_lvl[i] = '0;
        end
        for (int k = 0; k < `SAT_NUM_CLAUSES; k++) begin
            m_cls[k] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        read_all_vars();
        repeat (4) begin
            r = $random(seed);
            v = r & 7;
            rec.val.pol = r[3] ? POL_TRUE : POL_FALSE;
            rec.val.implied = r[4];
            rec.lvl = r[15:8];
            load_var(v, rec);
            read_var(v);
            load_var(v, '0);
        end
        finish_test("reset, load and read");

        r = $random(seed);
        ch = r[4:0];
        decide_var(0, ch[0]);
        read_var(0);
        finish_test("decide");

        // chain x0 -> x1 -> x2 -> x3 with random polarities
        for (int i = 0; i < 3; i++) begin
            lits = '0;
            lits[i] = lit_of(!ch[i]);
            lits[i+1] = lit_of(ch[i+1]);
            write_clause(i, lits);
        end
        propagate();
        for (int i = 0; i < 4; i++) begin
            read_var(i);
        end
        finish_test("propagate chain");

        // x5 forced both ways, clauses 4 and 5 both end falsified
        decide_var(4, ch[4]);
        lits = '0;
        lits[4] = lit_of(!ch[4]);
        lits[5] = LIT_POS;
        write_clause(3, lits);
        lits[5] = LIT_NEG;
        write_clause(5, lits);
        lits[1] = lit_of(!ch[1]);
        write_clause(4, lits);
        propagate();
        read_var(5);
        finish_test("propagate conflict");

        analyze_conflict();
        finish_test("analyze");

        backtrack();
        read_all_vars();
        r = $random(seed);
        decide_var(6, r[0]);
        read_var(6);
        finish_test("backtrack");

        $display("tests: %0d  failed: %0d  errors: %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+common
common/sat_pkg.sv
var_bin/var_state.sv
var_bin/var_bin.sv
logic/clause_eval.sv
logic/sat_bin_ctrl.sv
logic/sat_bin_top.sv
verif/tb_sat_bin.sv

// ==== Makefile ====
# Verilator build and run of the SAT bin testbench

VERILATOR ?= verilator
TOP       ?= tb_sat_bin
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(TOP)

# the log decides pass or fail
run: compile
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
